//--- logic/condUnit.sv
`timescale 1ns/100ps
`include "ctrl_macros.svh"

module condUnit (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  stallE,
  input  ctrlPkg::condT         cond,
  input  logic [`FLAG_WR_W-1:0] flagWrite,
  input  ctrlPkg::flagsT        flagsE,      // Fresh ALU flags
  input  logic                  branch,
  input  logic                  memWrite,
  input  logic                  regWrite,
  input  logic                  pcSrc,
  output logic                  condExE,
  output logic                  branchTakenE,
  output logic                  memWriteG,
  output logic                  regWriteG,
  output logic                  pcSrcG
);

  import ctrlPkg::*;

  flagsT flagsQ;     // Stored NZCV
  logic  geQ;        // Signed greater or equal

  assign geQ = (flagsQ.n == flagsQ.v);

  // ======================================================================
  // Condition check
  // ======================================================================
  always_comb begin
    case (cond)
      EQ:     condExE = flagsQ.z;
      NE:     condExE = ~flagsQ.z;
      CS:     condExE = flagsQ.c;
      CC:     condExE = ~flagsQ.c;
      MI:     condExE = flagsQ.n;
      PL:     condExE = ~flagsQ.n;
      VS:     condExE = flagsQ.v;
      VC:     condExE = ~flagsQ.v;
      HI:     condExE = flagsQ.c & ~flagsQ.z;       // Unsigned higher
      LS:     condExE = ~flagsQ.c | flagsQ.z;
      GE:     condExE = geQ;
      LT:     condExE = ~geQ;
      GT:     condExE = ~flagsQ.z & geQ;
      LE:     condExE = flagsQ.z | ~geQ;
      AL, NV: condExE = 1'b1;
    endcase
  end

  // Side effects only for executed instructions
  assign branchTakenE = branch & condExE;
  assign memWriteG    = memWrite & condExE;
  assign regWriteG    = regWrite & condExE;
  assign pcSrcG       = pcSrc & condExE;

  // ======================================================================
  // Flags register
  // ======================================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagsQ <= '0;
    end else if (!stallE && condExE) begin
      if (flagWrite[1]) begin          // Logical and arithmetic ops
        flagsQ.n <= flagsE.n;
        flagsQ.z <= flagsE.z;
      end
      if (flagWrite[0]) begin          // Arithmetic only
        flagsQ.c <= flagsE.c;
        flagsQ.v <= flagsE.v;
      end
    end
  end

  brTakenNeedsCond: assert property (@(posedge clk) disable iff (!arstN)
    branchTakenE |-> condExE)
    else $error("condUnit: branch taken with condition failed");

endmodule

//--- logic/ctrlPkg.sv
`include "ctrl_macros.svh"

package ctrlPkg;

  // Condition field, bits 31:28
  typedef enum logic [`COND_W-1:0] {
    EQ, NE, CS, CC,
    MI, PL, VS, VC,
    HI, LS, GE, LT,
    GT, LE, AL, NV   // NV runs as AL on this core
  } condT;

  // NZCV, same order as the status register
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Decode -> Execute
  typedef struct packed {
    logic                  aluSrc;
    logic [`ALU_CTRL_W-1:0] aluControl;
    logic [`FLAG_WR_W-1:0]  flagWrite;   // [1] NZ, [0] CV
    logic                  branch;
    logic                  memWrite;
    logic                  regWrite;
    logic                  memtoReg;
    logic                  pcSrc;
    condT                  cond;
    logic                  multEnable;
    logic                  ldst;        // Load or store
    logic                  loadByte;    // B bit
    logic                  storeLoad;   // L bit
  } exCtrlT;

  // Execute -> Memory, write enables already condition gated
  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] byteMask;
    logic       loadByte;
    logic [1:0] byteOffset;
  } memCtrlT;

  // Memory -> Writeback
  typedef struct packed {
    logic       memtoReg;
    logic       regWrite;
    logic       pcSrc;
    logic       loadByte;
    logic [1:0] byteOffset;
  } wbCtrlT;

endpackage

//--- logic/ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// Datapath and field widths
`define WORD_W      32
`define ALU_CTRL_W  4
`define FLAG_WR_W   2
`define COND_W      4

// Register index of the program counter
`define PC_REG      4'd15

// ALU control codes used outside the data-processing opcodes
`define ALU_ADD     4'b0100
`define ALU_SUB     4'b0010

// Instruction class, bits 27:26
`define OP_DP       2'b00
`define OP_MEM      2'b01
`define OP_BR       2'b10

// Bits 7:4 of a multiply
`define MUL_FUNCT   4'b1001

`endif

//--- logic/instrDecoder.sv
`timescale 1ns/100ps
`include "ctrl_macros.svh"

module instrDecoder (
  input  logic [`WORD_W-1:0]     instrD,
  output logic [1:0]             regSrcD,
  output logic [1:0]             immSrcD,
  output logic                   aluSrc,
  output logic                   memtoReg,
  output logic                   regWrite,
  output logic                   memWrite,
  output logic                   branch,
  output logic                   pcSrc,
  output logic                   multEnable,
  output logic                   ldst,
  output logic                   loadByte,
  output logic                   storeLoad,
  output logic [`ALU_CTRL_W-1:0] aluControl,
  output logic [`FLAG_WR_W-1:0]  flagWrite,
  output ctrlPkg::condT          cond
);

  import ctrlPkg::*;

  logic aluOp;  // Data-processing class, ALU code comes from the opcode

  // ======================================================================
  // Main decoder
  // ======================================================================
  always_comb begin
    regSrcD    = 2'b00;
    immSrcD    = 2'b00;
    aluSrc     = 1'b0;
    memtoReg   = 1'b0;
    regWrite   = 1'b0;
    memWrite   = 1'b0;
    branch     = 1'b0;
    multEnable = 1'b0;
    aluOp      = 1'b0;
    case (instrD[27:26])
      `OP_DP: begin
        regWrite = 1'b1;
        aluOp    = 1'b1;
        if (instrD[25]) begin
          aluSrc = 1'b1;                                 // Rotated imm8
        end else begin
          multEnable = (instrD[7:4] == `MUL_FUNCT);      // MUL shares the reg form
        end
      end
      `OP_MEM: begin
        immSrcD = 2'b01;                                 // imm12 offset
        if (instrD[20]) begin                            // LDR / LDRB
          memtoReg = 1'b1;
          regWrite = 1'b1;
          aluSrc   = ~instrD[25];                        // I clear means immediate offset
        end else begin                                   // STR / STRB
          regSrcD  = 2'b10;                              // Rd read on second port
          aluSrc   = 1'b1;
          memWrite = 1'b1;
        end
      end
      `OP_BR: begin
        regSrcD = 2'b01;                                 // PC as first operand
        immSrcD = 2'b10;                                 // imm24
        aluSrc  = 1'b1;
        branch  = 1'b1;
      end
      default: begin
        // Coprocessor space, nothing issued
      end
    endcase
  end

  // ======================================================================
  // ALU control
  // ======================================================================
  always_comb begin
    if (aluOp) begin
      aluControl = instrD[24:21];                        // Opcode passes straight through
      flagWrite  = {2{instrD[20]}};                      // S bit
    end else if (ldst) begin
      aluControl = instrD[23] ? `ALU_ADD : `ALU_SUB;     // U bit picks offset direction
      flagWrite  = 2'b00;
    end else begin
      aluControl = `ALU_ADD;                             // Branch target add
      flagWrite  = 2'b00;
    end
  end

  // Memory access fields
  assign ldst      = (instrD[27:26] == `OP_MEM);
  assign loadByte  = ldst & instrD[22];
  assign storeLoad = ldst & instrD[20];

  // Any write to r15 redirects fetch
  assign pcSrc = branch | (regWrite & (instrD[15:12] == `PC_REG));
  assign cond  = condT'(instrD[31:28]);

  // Load and store never issue together
  always_comb begin
    memLoadStoreExcl: assert (!(memWrite && memtoReg))
      else $error("instrDecoder: load and store decoded together");
  end

endmodule

//--- logic/memAccessCtrl.sv
`timescale 1ns/100ps
`include "ctrl_macros.svh"

module memAccessCtrl (
  input  logic               ldst,
  input  logic               loadByte,     // B bit
  input  logic               storeLoad,    // L bit
  input  logic [`WORD_W-1:0] aluResultE,   // Effective address
  output logic [3:0]         byteMask,
  output logic [1:0]         byteOffset,
  output logic               writeByteE
);

  logic [1:0] laneSel;  // Byte lane within the word

  assign laneSel = aluResultE[1:0];

  // One lane for byte access, all four for word
  always_comb begin
    if (loadByte) begin
      byteMask = 4'b0001 << laneSel;
    end else begin
      byteMask = 4'b1111;
    end
  end

  assign byteOffset = laneSel;                 // Load data alignment in Writeback
  assign writeByteE = ldst & loadByte & ~storeLoad;  // STRB

  // Some lane always enabled
  always_comb begin
    maskNonZero: assert (byteMask != 4'b0000)
      else $error("memAccessCtrl: empty byte mask");
  end

endmodule

//--- logic/pipeController.sv
`timescale 1ns/100ps
`include "ctrl_macros.svh"

module pipeController (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`WORD_W-1:0]     instrD,
  input  ctrlPkg::flagsT         flagsE,
  input  logic [`WORD_W-1:0]     aluResultE,
  // Hazard levels
  input  logic                   stallE,
  input  logic                   flushE,
  input  logic                   stallM,
  input  logic                   stallW,
  input  logic                   flushW,
  // Decode
  output logic [1:0]             regSrcD,
  output logic [1:0]             immSrcD,
  // Execute
  output logic                   aluSrcE,
  output logic [`ALU_CTRL_W-1:0] aluControlE,
  output logic                   multEnableE,
  output logic                   memtoRegE,
  output logic                   branchTakenE,
  output logic                   writeByteE,
  // Memory
  output logic                   memWriteM,
  output logic                   memtoRegM,
  output logic                   regWriteM,
  output logic [3:0]             byteMaskM,
  // Writeback
  output logic                   memtoRegW,
  output logic                   regWriteW,
  output logic                   pcSrcW,
  output logic                   loadByteW,
  output logic [1:0]             byteOffsetW
);

  import ctrlPkg::*;

  // Decode fields
  logic                   aluSrcD, memtoRegD, regWriteD, memWriteD;
  logic                   branchD, pcSrcD, multEnableD;
  logic                   ldstD, loadByteD, storeLoadD;
  logic [`ALU_CTRL_W-1:0] aluControlD;
  logic [`FLAG_WR_W-1:0]  flagWriteD;
  condT                   condD;

  exCtrlT  exD, exE;
  memCtrlT memE, memM;
  wbCtrlT  wbM, wbW;

  logic       memWriteG, regWriteG, pcSrcG;   // Condition gated
  logic [3:0] byteMaskE;
  logic [1:0] byteOffsetE;

  // ======================================================================
  // Decode
  // ======================================================================
  instrDecoder decoder (
    .instrD     (instrD),
    .regSrcD    (regSrcD),
    .immSrcD    (immSrcD),
    .aluSrc     (aluSrcD),
    .memtoReg   (memtoRegD),
    .regWrite   (regWriteD),
    .memWrite   (memWriteD),
    .branch     (branchD),
    .pcSrc      (pcSrcD),
    .multEnable (multEnableD),
    .ldst       (ldstD),
    .loadByte   (loadByteD),
    .storeLoad  (storeLoadD),
    .aluControl (aluControlD),
    .flagWrite  (flagWriteD),
    .cond       (condD)
  );

  always_comb begin
    exD.aluSrc     = aluSrcD;
    exD.aluControl = aluControlD;
    exD.flagWrite  = flagWriteD;
    exD.branch     = branchD;
    exD.memWrite   = memWriteD;
    exD.regWrite   = regWriteD;
    exD.memtoReg   = memtoRegD;
    exD.pcSrc      = pcSrcD;
    exD.cond       = condD;
    exD.multEnable = multEnableD;
    exD.ldst       = ldstD;
    exD.loadByte   = loadByteD;
    exD.storeLoad  = storeLoadD;
  end

  // ======================================================================
  // Execute
  // ======================================================================
  stageReg #(.payloadT(exCtrlT)) exReg (
    .clk (clk), .arstN (arstN), .en (~stallE), .clr (flushE), .d (exD), .q (exE)
  );

  assign aluSrcE     = exE.aluSrc;
  assign aluControlE = exE.aluControl;
  assign memtoRegE   = exE.memtoReg;
  assign multEnableE = exE.multEnable;

  condUnit cond (
    .clk          (clk),
    .arstN        (arstN),
    .stallE       (stallE),
    .cond         (exE.cond),
    .flagWrite    (exE.flagWrite),
    .flagsE       (flagsE),
    .branch       (exE.branch),
    .memWrite     (exE.memWrite),
    .regWrite     (exE.regWrite),
    .pcSrc        (exE.pcSrc),
    .condExE      (),                        // Only consumed inside condUnit
    .branchTakenE (branchTakenE),
    .memWriteG    (memWriteG),
    .regWriteG    (regWriteG),
    .pcSrcG       (pcSrcG)
  );

  memAccessCtrl memAccess (
    .ldst       (exE.ldst),
    .loadByte   (exE.loadByte),
    .storeLoad  (exE.storeLoad),
    .aluResultE (aluResultE),
    .byteMask   (byteMaskE),
    .byteOffset (byteOffsetE),
    .writeByteE (writeByteE)
  );

  always_comb begin
    memE.memWrite   = memWriteG;
    memE.memtoReg   = exE.memtoReg;
    memE.regWrite   = regWriteG;
    memE.pcSrc      = pcSrcG;
    memE.byteMask   = byteMaskE;
    memE.loadByte   = exE.loadByte;
    memE.byteOffset = byteOffsetE;
  end

  // ======================================================================
  // Memory and Writeback
  // ======================================================================
  stageReg #(.payloadT(memCtrlT)) memReg (
    .clk (clk), .arstN (arstN), .en (~stallM), .clr (1'b0), .d (memE), .q (memM)
  );

  assign memWriteM = memM.memWrite;
  assign memtoRegM = memM.memtoReg;
  assign regWriteM = memM.regWrite;
  assign byteMaskM = memM.byteMask;

  always_comb begin
    wbM.memtoReg   = memM.memtoReg;
    wbM.regWrite   = memM.regWrite;
    wbM.pcSrc      = memM.pcSrc;
    wbM.loadByte   = memM.loadByte;
    wbM.byteOffset = memM.byteOffset;
  end

  stageReg #(.payloadT(wbCtrlT)) wbReg (
    .clk (clk), .arstN (arstN), .en (~stallW), .clr (flushW), .d (wbM), .q (wbW)
  );

  assign memtoRegW   = wbW.memtoReg;
  assign regWriteW   = wbW.regWrite;
  assign pcSrcW      = wbW.pcSrc;
  assign loadByteW   = wbW.loadByte;
  assign byteOffsetW = wbW.byteOffset;

endmodule

//--- logic/stageReg.sv
`timescale 1ns/100ps
`include "ctrl_macros.svh"

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    arstN,
  input  logic    en,    // Low while the stage is stalled
  input  logic    clr,   // Bubble insert, beats en
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      q <= '0;
    end else if (clr) begin
      q <= '0;           // Flush
    end else if (en) begin
      q <= d;
    end
    // Stall holds q
  end

endmodule

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the pipeController testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
  --top-module pipeControllerTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/VpipeControllerTb)
simStatus=$?
echo "$simOutput"

if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "Test completed successfully"; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi

//--- sources.f
+incdir+logic
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/stageReg.sv
logic/condUnit.sv
logic/memAccessCtrl.sv
logic/pipeController.sv
verif/pipeControllerTb.sv

//--- verif/pipeControllerTb.sv
`timescale 1ns/100ps
`include "ctrl_macros.svh"

module pipeControllerTb;

  import ctrlPkg::*;

  localparam int unsigned        SEED        = 32'h549d_31f8;
  localparam int                 NUM_TESTS   = 7;
  localparam int                 CYCLE_NS    = 4;
  localparam int                 WATCHDOG_NS = NUM_TESTS * 40 * CYCLE_NS;  // 40 cycles per test
  localparam logic [`WORD_W-1:0] NOP_INSTR   = 32'hEC00_0000;  // Class 11, issues nothing

  logic                   clk;
  logic                   arstN;
  logic [`WORD_W-1:0]     instrD;
  flagsT                  flagsE;
  logic [`WORD_W-1:0]     aluResultE;
  logic                   stallE, flushE, stallM, stallW, flushW;
  logic [1:0]             regSrcD, immSrcD;
  logic                   aluSrcE, multEnableE, memtoRegE, branchTakenE, writeByteE;
  logic [`ALU_CTRL_W-1:0] aluControlE;
  logic                   memWriteM, memtoRegM, regWriteM;
  logic [3:0]             byteMaskM;
  logic                   memtoRegW, regWriteW, pcSrcW, loadByteW;
  logic [1:0]             byteOffsetW;

  int          errorCount;
  int          checkCount;

  pipeController dut (.*);

  always #(CYCLE_NS / 2) clk = ~clk;

  // ======================================================================
  // Encoders and compare tasks
  // ======================================================================
  function automatic logic [31:0] encDp(condT cond, logic immBit, logic [3:0] opcode,
                                        logic sBit, logic [3:0] rd, logic [3:0] funct);
    return {cond, `OP_DP, immBit, opcode, sBit, 4'd0, rd, 4'd0, funct, 4'd0};
  endfunction

  // Pre-indexed, no writeback
  function automatic logic [31:0] encMem(condT cond, logic regOff, logic up, logic byteBit,
                                         logic load, logic [3:0] rd, logic [11:0] offset);
    return {cond, `OP_MEM, regOff, 1'b1, up, byteBit, 1'b0, load, 4'd0, rd, offset};
  endfunction

  function automatic logic [31:0] encBr(condT cond, logic [23:0] imm);
    return {cond, `OP_BR, 2'b10, imm};
  endfunction

  function automatic logic [3:0] pickReg();
    return 4'($urandom % 15);  // Anything but r15
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #0.5;                      // Drive point, registered outputs settled
  endtask

  task automatic checkBit(string what, logic got, logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkSel(string what, logic [1:0] got, logic [1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkCode(string what, logic [`ALU_CTRL_W-1:0] got,
                           logic [`ALU_CTRL_W-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkMask(string what, logic [3:0] got, logic [3:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Gated write seen downstream of a flag update
  task automatic checkFlagsEffect(string what, flagsT applied, logic got, logic exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s (flagsE nzcv %b) gave %b, expected %b",
               $time, what, applied, got, exp);
    end
  endtask

  // Present in Decode, return with it in Memory
  task automatic runToMemory(logic [31:0] instr);
    instrD = instr;
    nextCycle();
    instrD = NOP_INSTR;
    nextCycle();
  endtask

  // ======================================================================
  // Tests
  // ======================================================================
  task automatic testResetState();
    checkBit("reset aluSrcE", aluSrcE, 1'b0);
    checkCode("reset aluControlE", aluControlE, 4'b0000);
    checkBit("reset branchTakenE", branchTakenE, 1'b0);
    checkBit("reset memWriteM", memWriteM, 1'b0);
    checkBit("reset regWriteM", regWriteM, 1'b0);
    checkMask("reset byteMaskM", byteMaskM, 4'b0000);
    checkBit("reset regWriteW", regWriteW, 1'b0);
    checkBit("reset pcSrcW", pcSrcW, 1'b0);
  endtask

  task automatic decodeCase(string what, logic [31:0] instr, logic [1:0] expRegSrc,
                            logic [1:0] expImmSrc, logic expAluSrc,
                            logic [`ALU_CTRL_W-1:0] expAluCtrl, logic expMult);
    instrD = instr;
    #1;                                   // Decode is combinational
    checkSel({what, " regSrcD"}, regSrcD, expRegSrc);
    checkSel({what, " immSrcD"}, immSrcD, expImmSrc);
    nextCycle();
    checkBit({what, " aluSrcE"}, aluSrcE, expAluSrc);
    checkCode({what, " aluControlE"}, aluControlE, expAluCtrl);
    checkBit({what, " multEnableE"}, multEnableE, expMult);
  endtask

  task automatic testDecodeTable();
    logic [3:0]  opcode;
    logic [3:0]  rd;
    logic [11:0] off;
    opcode = 4'($urandom);
    rd     = pickReg();
    off    = 12'($urandom);
    decodeCase("DP imm", encDp(AL, 1'b1, opcode, 1'b0, rd, 4'd0),
               2'b00, 2'b00, 1'b1, opcode, 1'b0);
    decodeCase("DP reg", encDp(AL, 1'b0, opcode, 1'b0, rd, 4'd0),
               2'b00, 2'b00, 1'b0, opcode, 1'b0);
    decodeCase("MUL", encDp(AL, 1'b0, 4'b0000, 1'b0, rd, `MUL_FUNCT),
               2'b00, 2'b00, 1'b0, 4'b0000, 1'b1);
    decodeCase("LDR up", encMem(AL, 1'b0, 1'b1, 1'b0, 1'b1, rd, off),
               2'b00, 2'b01, 1'b1, `ALU_ADD, 1'b0);
    decodeCase("STR down", encMem(AL, 1'b0, 1'b0, 1'b0, 1'b0, rd, off),
               2'b10, 2'b01, 1'b1, `ALU_SUB, 1'b0);
    decodeCase("B", encBr(AL, 24'($urandom)), 2'b01, 2'b10, 1'b1, `ALU_ADD, 1'b0);
    decodeCase("class 11", NOP_INSTR, 2'b00, 2'b00, 1'b0, `ALU_ADD, 1'b0);
  endtask

  // Flags still zero from reset here
  task automatic testCondGating();
    logic [3:0]  rd;
    logic [11:0] off;
    rd  = pickReg();
    off = 12'($urandom);
    runToMemory(encMem(AL, 1'b0, 1'b1, 1'b0, 1'b0, rd, off));
    checkBit("STR AL memWriteM", memWriteM, 1'b1);
    runToMemory(encMem(EQ, 1'b0, 1'b1, 1'b0, 1'b0, rd, off));
    checkBit("STR EQ memWriteM", memWriteM, 1'b0);
  endtask

  task automatic testFlagUpdate();
    logic [3:0]  rd;
    logic [11:0] off;
    rd  = pickReg();
    off = 12'($urandom);
    instrD = encDp(AL, 1'b1, 4'b1010, 1'b1, 4'd0, 4'd0);   // CMP, S set
    nextCycle();
    flagsE = flagsT'(4'b0100);                             // Z from the ALU
    instrD = encMem(EQ, 1'b0, 1'b1, 1'b0, 1'b1, rd, off);  // LDREQ right behind
    nextCycle();
    flagsE = flagsT'(4'b0000);
    instrD = NOP_INSTR;
    nextCycle();
    checkFlagsEffect("LDREQ after CMP", flagsT'(4'b0100), regWriteM, 1'b1);
    instrD = encDp(AL, 1'b1, 4'b1101, 1'b0, rd, 4'd0);     // MOV without S
    nextCycle();
    flagsE = flagsT'(4'b1011);                             // Would clear Z if taken
    instrD = encMem(EQ, 1'b0, 1'b1, 1'b0, 1'b1, rd, off);
    nextCycle();
    flagsE = flagsT'(4'b0000);
    instrD = NOP_INSTR;
    nextCycle();
    checkFlagsEffect("LDREQ after MOV", flagsT'(4'b1011), regWriteM, 1'b1);
  endtask

  task automatic testByteAccess();
    logic [31:0] addr;
    logic [3:0]  expMask;
    logic [3:0]  rd;
    logic [11:0] off;
    addr   = $urandom;
    expMask = 4'b0000;
    expMask[addr[1:0]] = 1'b1;             // Lane picked by the low address bits
    rd     = pickReg();
    off    = 12'($urandom);
    instrD = encMem(AL, 1'b0, 1'b1, 1'b1, 1'b1, rd, off);  // LDRB
    nextCycle();
    aluResultE = addr;                     // Address during Execute
    instrD     = NOP_INSTR;
    checkBit("LDRB writeByteE", writeByteE, 1'b0);
    nextCycle();
    checkMask("LDRB byteMaskM", byteMaskM, expMask);
    checkBit("LDRB byteMaskM one-hot", $onehot(byteMaskM), 1'b1);
    checkBit("LDRB memtoRegM", memtoRegM, 1'b1);
    nextCycle();
    checkSel("LDRB byteOffsetW", byteOffsetW, addr[1:0]);
    checkBit("LDRB loadByteW", loadByteW, 1'b1);
    checkBit("LDRB memtoRegW", memtoRegW, 1'b1);
    aluResultE = $urandom;
    runToMemory(encMem(AL, 1'b0, 1'b1, 1'b0, 1'b1, rd, off));   // Word LDR
    checkMask("LDR byteMaskM", byteMaskM, 4'b1111);
    instrD = encMem(AL, 1'b0, 1'b1, 1'b1, 1'b0, rd, off);        // STRB
    nextCycle();
    instrD = NOP_INSTR;
    checkBit("STRB writeByteE", writeByteE, 1'b1);
    aluResultE = '0;
  endtask

  task automatic testBranch();
    instrD = encBr(AL, 24'($urandom));
    nextCycle();
    instrD = NOP_INSTR;
    checkBit("B branchTakenE", branchTakenE, 1'b1);
    nextCycle();
    nextCycle();
    checkBit("B pcSrcW", pcSrcW, 1'b1);
    instrD = encDp(AL, 1'b1, 4'b1101, 1'b0, `PC_REG, 4'd0);      // MOV pc, #imm
    nextCycle();
    instrD = NOP_INSTR;
    checkBit("MOV pc branchTakenE", branchTakenE, 1'b0);
    nextCycle();
    nextCycle();
    checkBit("MOV pc pcSrcW", pcSrcW, 1'b1);
    checkBit("MOV pc regWriteW", regWriteW, 1'b1);
  endtask

  task automatic testStallFlush();
    logic [3:0]  opcode;
    logic [3:0]  rd;
    logic [11:0] off;
    opcode = 4'($urandom) | 4'b0001;       // Nonzero so a flush shows
    rd     = pickReg();
    off    = 12'($urandom);
    instrD = encDp(AL, 1'b1, opcode, 1'b0, rd, 4'd0);
    flushE = 1'b1;
    nextCycle();
    flushE = 1'b0;
    checkBit("flushed aluSrcE", aluSrcE, 1'b0);
    checkCode("flushed aluControlE", aluControlE, 4'b0000);
    instrD = encMem(AL, 1'b0, 1'b1, 1'b0, 1'b1, rd, off);       // LDR to hold
    nextCycle();
    checkBit("LDR memtoRegE", memtoRegE, 1'b1);
    stallE = 1'b1;
    instrD = encDp(AL, 1'b0, 4'b0000, 1'b0, rd, `MUL_FUNCT);    // MUL waits in Decode
    repeat (2) begin
      nextCycle();
      checkBit("stalled memtoRegE", memtoRegE, 1'b1);
      checkCode("stalled aluControlE", aluControlE, `ALU_ADD);
      checkBit("stalled multEnableE", multEnableE, 1'b0);
    end
    stallE = 1'b0;
    nextCycle();
    checkBit("released multEnableE", multEnableE, 1'b1);
    instrD = NOP_INSTR;
  endtask

  // ======================================================================
  // Run
  // ======================================================================
  initial begin
    void'($urandom(SEED));
    errorCount = 0;
    checkCount = 0;
    clk        = 1'b0;
    arstN      = 1'b0;
    instrD     = NOP_INSTR;
    flagsE     = '0;
    aluResultE = '0;
    stallE     = 1'b0;
    flushE     = 1'b0;
    stallM     = 1'b0;
    stallW     = 1'b0;
    flushW     = 1'b0;
    repeat (5) @(posedge clk);
    #0.5;
    arstN = 1'b1;
    testResetState();
    testDecodeTable();
    testCondGating();
    testFlagUpdate();
    testByteAccess();
    testBranch();
    testStallFlush();
    nextCycle();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Hang guard
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t before all tests finished", $time);
    $display("Test failed");
    $finish;
  end

endmodule
